/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t REG_RA = 5'd31;   // Link register

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_COP0    = 6'b010000;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL function field
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;

    localparam logic [4:0] RT_BLTZ = 5'b00000;   // REGIMM rt field
    localparam logic [4:0] RT_BGEZ = 5'b00001;
    localparam logic [4:0] RS_MFC0 = 5'b00000;   // COP0 rs field
    localparam logic [4:0] RS_MTC0 = 5'b00100;
    localparam logic [4:0] RS_ERET = 5'b10000;   // CO bit set

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_fmt_t;

    // One instruction word, three field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

`default_nettype wire

/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'd0,
        SEL_LOGIC       = 3'd1,
        SEL_SHIFT       = 3'd2,
        SEL_ARITH       = 3'd3,
        SEL_MOVE        = 3'd4,
        SEL_JUMP_BRANCH = 3'd5,
        SEL_LOAD_STORE  = 3'd6
    } alu_sel_e;

    // Upper nibble follows the operation class
    typedef enum logic [7:0] {
        NOP_OP  = 8'h00,
        AND_OP  = 8'h10, OR_OP   = 8'h11, XOR_OP  = 8'h12, NOR_OP  = 8'h13,
        SLL_OP  = 8'h20, SRL_OP  = 8'h21, SRA_OP  = 8'h22,
        ADD_OP  = 8'h30, ADDU_OP = 8'h31, SUB_OP  = 8'h32, SUBU_OP = 8'h33,
        SLT_OP  = 8'h34, SLTU_OP = 8'h35,
        MFC0_OP = 8'h40, MTC0_OP = 8'h41,
        JR_OP   = 8'h50, JALR_OP = 8'h51, J_OP    = 8'h52, JAL_OP  = 8'h53,
        BEQ_OP  = 8'h54, BNE_OP  = 8'h55, BGTZ_OP = 8'h56, BLEZ_OP = 8'h57,
        BGEZ_OP = 8'h58, BLTZ_OP = 8'h59,
        LW_OP   = 8'h60, SW_OP   = 8'h61,
        ERET_OP = 8'h70
    } alu_op_e;

    ////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic      reg1_read;
        reg_addr_t reg1_addr;
        logic      reg2_read;
        reg_addr_t reg2_addr;
    } rd_req_t;

    typedef struct packed {
        alu_sel_e  alusel;
        alu_op_e   aluop;
        logic      w_reg;
        reg_addr_t w_dest;
        word_t     imm;
        logic      valid;   // Low for a bubble
    } id_ex_t;

    typedef struct packed {
        logic  inst_invalid;
        logic  is_eret;
        word_t pc;
    } except_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_t;

endpackage

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  isa_pkg::inst_u     inst_i,
    input  isa_pkg::word_t     pc_i,
    output pipe_pkg::id_ex_t   ex_o,
    output pipe_pkg::except_t  exc_o,
    output pipe_pkg::rd_req_t  rd_req_o,
    output pipe_pkg::jump_t    jump_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // Operation class is fixed by the operation
    function automatic alu_sel_e sel_of(input alu_op_e op);
        case (op)
            AND_OP, OR_OP, XOR_OP, NOR_OP:
                sel_of = SEL_LOGIC;
            SLL_OP, SRL_OP, SRA_OP:
                sel_of = SEL_SHIFT;
            ADD_OP, ADDU_OP, SUB_OP, SUBU_OP, SLT_OP, SLTU_OP:
                sel_of = SEL_ARITH;
            MFC0_OP, MTC0_OP:
                sel_of = SEL_MOVE;
            JR_OP, JALR_OP, J_OP, JAL_OP, BEQ_OP, BNE_OP,
            BGTZ_OP, BLEZ_OP, BGEZ_OP, BLTZ_OP:
                sel_of = SEL_JUMP_BRANCH;
            LW_OP, SW_OP:
                sel_of = SEL_LOAD_STORE;
            default:
                sel_of = SEL_NOP;   // NOP and ERET
        endcase
    endfunction

    alu_op_e op;
    logic    known;
    word_t   pc_plus_4;
    word_t   j_target;
    word_t   sext_imm;
    word_t   zext_imm;

    assign pc_plus_4 = pc_i + 32'd4;
    assign j_target  = {pc_plus_4[31:28], inst_i.j_fmt.index26, 2'b00};
    assign sext_imm  = {{16{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16};
    assign zext_imm  = {16'h0000, inst_i.i_fmt.imm16};

    always_comb begin
        op                 = NOP_OP;
        known              = 1'b0;
        rd_req_o.reg1_read = 1'b0;
        rd_req_o.reg1_addr = inst_i.r_fmt.rs;
        rd_req_o.reg2_read = 1'b0;
        rd_req_o.reg2_addr = inst_i.r_fmt.rt;
        ex_o.w_reg         = 1'b0;
        ex_o.w_dest        = inst_i.r_fmt.rd;
        ex_o.imm           = '0;
        exc_o.is_eret      = 1'b0;
        jump_o.taken       = 1'b0;
        jump_o.target      = '0;

        case (inst_i.r_fmt.opcode)
            OP_SPECIAL: begin
                case (inst_i.r_fmt.funct)
                    FN_AND:  op = AND_OP;
                    FN_OR:   op = OR_OP;
                    FN_XOR:  op = XOR_OP;
                    FN_NOR:  op = NOR_OP;
                    FN_SLLV: op = SLL_OP;
                    FN_SRLV: op = SRL_OP;
                    FN_SRAV: op = SRA_OP;
                    FN_ADD:  op = ADD_OP;
                    FN_ADDU: op = ADDU_OP;
                    FN_SUB:  op = SUB_OP;
                    FN_SUBU: op = SUBU_OP;
                    FN_SLT:  op = SLT_OP;
                    FN_SLTU: op = SLTU_OP;
                    FN_JR:   op = JR_OP;
                    FN_JALR: op = JALR_OP;
                    default: op = NOP_OP;
                endcase
                if (op != NOP_OP) begin
                    known              = 1'b1;
                    rd_req_o.reg1_read = 1'b1;
                    rd_req_o.reg2_read = (op != JR_OP) && (op != JALR_OP);
                    ex_o.w_reg         = (op != JR_OP);
                end
                // Shift amount of constant shifts rides in imm
                if (inst_i.r_fmt.rs == '0 && (inst_i.r_fmt.funct == FN_SLL ||
                    inst_i.r_fmt.funct == FN_SRL || inst_i.r_fmt.funct == FN_SRA)) begin
                    case (inst_i.r_fmt.funct)
                        FN_SRL:  op = SRL_OP;
                        FN_SRA:  op = SRA_OP;
                        default: op = SLL_OP;
                    endcase
                    known              = 1'b1;
                    rd_req_o.reg2_read = 1'b1;
                    ex_o.w_reg         = 1'b1;
                    ex_o.imm           = {27'd0, inst_i.r_fmt.shamt};
                end
            end

            OP_REGIMM: begin
                case (inst_i.r_fmt.rt)
                    RT_BGEZ: op = BGEZ_OP;
                    RT_BLTZ: op = BLTZ_OP;
                    default: op = NOP_OP;
                endcase
                known              = (op != NOP_OP);
                rd_req_o.reg1_read = known;
                ex_o.imm           = sext_imm;   // Branch offset
            end

            OP_COP0: begin
                case (inst_i.r_fmt.rs)
                    RS_MFC0: begin
                        op          = MFC0_OP;
                        ex_o.w_reg  = 1'b1;
                        ex_o.w_dest = inst_i.r_fmt.rt;
                    end
                    RS_MTC0: begin
                        op                 = MTC0_OP;
                        rd_req_o.reg1_read = 1'b1;
                        rd_req_o.reg1_addr = inst_i.r_fmt.rt;
                    end
                    RS_ERET: begin
                        op            = ERET_OP;
                        exc_o.is_eret = 1'b1;
                    end
                    default: op = NOP_OP;
                endcase
                known = (op != NOP_OP);
            end

            ////////////////////////////////////////
            // Memory, jumps and branches
            ////////////////////////////////////////
            OP_LW, OP_SW: begin
                op                 = (inst_i.r_fmt.opcode == OP_LW) ? LW_OP : SW_OP;
                known              = 1'b1;
                rd_req_o.reg1_read = 1'b1;                // Base
                rd_req_o.reg2_read = (op == SW_OP);       // Store data
                ex_o.w_reg         = (op == LW_OP);
                ex_o.w_dest        = inst_i.i_fmt.rt;
                ex_o.imm           = sext_imm;
            end

            OP_J, OP_JAL: begin
                op            = (inst_i.r_fmt.opcode == OP_JAL) ? JAL_OP : J_OP;
                known         = 1'b1;
                ex_o.w_reg    = (op == JAL_OP);
                ex_o.w_dest   = REG_RA;
                jump_o.taken  = 1'b1;
                jump_o.target = j_target;
            end

            OP_BEQ, OP_BNE: begin
                op                 = (inst_i.r_fmt.opcode == OP_BEQ) ? BEQ_OP : BNE_OP;
                known              = 1'b1;
                rd_req_o.reg1_read = 1'b1;
                rd_req_o.reg2_read = 1'b1;
                ex_o.imm           = sext_imm;
            end

            OP_BGTZ, OP_BLEZ: begin
                op                 = (inst_i.r_fmt.opcode == OP_BGTZ) ? BGTZ_OP : BLEZ_OP;
                known              = 1'b1;
                rd_req_o.reg1_read = 1'b1;
                ex_o.imm           = sext_imm;
            end

            OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
                case (inst_i.r_fmt.opcode)
                    OP_ANDI: op = AND_OP;
                    OP_XORI: op = XOR_OP;
                    default: op = OR_OP;   // ORI and LUI as rs | imm
                endcase
                known              = 1'b1;
                rd_req_o.reg1_read = 1'b1;
                ex_o.w_reg         = 1'b1;
                ex_o.w_dest        = inst_i.i_fmt.rt;
                ex_o.imm           = (inst_i.r_fmt.opcode == OP_LUI) ?
                                     {inst_i.i_fmt.imm16, 16'h0000} : zext_imm;
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                case (inst_i.r_fmt.opcode)
                    OP_ADDIU: op = ADDU_OP;
                    OP_SLTI:  op = SLT_OP;
                    OP_SLTIU: op = SLTU_OP;
                    default:  op = ADD_OP;
                endcase
                known              = 1'b1;
                rd_req_o.reg1_read = 1'b1;
                ex_o.w_reg         = 1'b1;
                ex_o.w_dest        = inst_i.i_fmt.rt;
                ex_o.imm           = sext_imm;
            end

            default: op = NOP_OP;
        endcase

        ex_o.aluop         = op;
        ex_o.alusel        = sel_of(op);
        ex_o.valid         = 1'b1;   // A word is always present in ID
        exc_o.inst_invalid = ~known;
        exc_o.pc           = pc_i;
    end

endmodule

`default_nettype wire

/* verilog/load_use_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module load_use_hazard (
    input  pipe_pkg::rd_req_t rd_req_i,
    input  pipe_pkg::id_ex_t  ex_i,
    output logic              stall_o
);

    import pipe_pkg::*;

    logic ex_is_load;
    logic hit1;
    logic hit2;

    assign ex_is_load = (ex_i.aluop == LW_OP);
    assign hit1       = rd_req_i.reg1_read && (rd_req_i.reg1_addr == ex_i.w_dest);
    assign hit2       = rd_req_i.reg2_read && (rd_req_i.reg2_addr == ex_i.w_dest);

    // r0 never carries a loaded value
    assign stall_o = ex_is_load && (ex_i.w_dest != '0) && (hit1 || hit2);

endmodule

`default_nettype wire

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              flush_i,
    input  pipe_pkg::id_ex_t  ex_i,
    input  pipe_pkg::except_t exc_i,
    output pipe_pkg::id_ex_t  ex_o,
    output pipe_pkg::except_t exc_o
);

    // All-zero bubble means NOP with no write and no flags
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ex_o  <= '0;
            exc_o <= '0;
        end else begin
            ex_o  <= ex_i;
            exc_o <= exc_i;   // Invalid words pass on as valid with the flag
        end
    end

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  isa_pkg::inst_u    inst_i,
    input  isa_pkg::word_t    pc_i,
    output pipe_pkg::rd_req_t rd_req_o,
    output pipe_pkg::jump_t   jump_o,
    output logic              stall_o,
    output pipe_pkg::id_ex_t  ex_o,
    output pipe_pkg::except_t exc_o
);

    import pipe_pkg::*;

    id_ex_t  dec_ex;
    except_t dec_exc;
    rd_req_t dec_rd_req;
    jump_t   dec_jump;

    inst_decoder u_decoder (
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .ex_o     (dec_ex),
        .exc_o    (dec_exc),
        .rd_req_o (dec_rd_req),
        .jump_o   (dec_jump)
    );

    assign rd_req_o = dec_rd_req;
    assign jump_o   = dec_jump;

    // EX side comes from our own ID/EX register
    load_use_hazard u_hazard (
        .rd_req_i (dec_rd_req),
        .ex_i     (ex_o),
        .stall_o  (stall_o)
    );

    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (stall_o),   // Bubble while the load is in EX
        .ex_i    (dec_ex),
        .exc_i   (dec_exc),
        .ex_o    (ex_o),
        .exc_o   (exc_o)
    );

endmodule

`default_nettype wire

/* bench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TIMEOUT_NS = 6 * 40 * 100;   // Tests x cycles x period

    logic        clk = 1'b0;
    logic        rst_i;
    inst_u       inst_i;
    word_t       pc_i;
    rd_req_t     rd_req_o;
    jump_t       jump_o;
    logic        stall_o;
    id_ex_t      ex_o;
    except_t     exc_o;
    logic [31:0] seed = 32'd52767;
    int          passes = 0;
    int          errors = 0;

    id_stage u_dut (
        .clk      (clk),
        .rst_i    (rst_i),
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .rd_req_o (rd_req_o),
        .jump_o   (jump_o),
        .stall_o  (stall_o),
        .ex_o     (ex_o),
        .exc_o    (exc_o)
    );

    always #50 clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Random numbers and encodings
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        seed = xorshift32(seed);
        return seed;
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] v;
        v = rand32();
        return v[4:0];
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] v;
        v = rand32();
        return v[15:0];
    endfunction

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sh,
                                     input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_inst(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_inst(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    ////////////////////////////////////////
    // Expected bundles
    ////////////////////////////////////////
    function automatic id_ex_t make_ex(input alu_sel_e sel, input alu_op_e op,
                                       input logic w_reg, input reg_addr_t dest,
                                       input word_t imm);
        id_ex_t e;
        e.alusel = sel;
        e.aluop  = op;
        e.w_reg  = w_reg;
        e.w_dest = dest;
        e.imm    = imm;
        e.valid  = 1'b1;
        return e;
    endfunction

    function automatic rd_req_t make_req(input logic r1, input reg_addr_t a1,
                                         input logic r2, input reg_addr_t a2);
        rd_req_t r;
        r.reg1_read = r1;
        r.reg1_addr = a1;
        r.reg2_read = r2;
        r.reg2_addr = a2;
        return r;
    endfunction

    function automatic except_t make_exc(input logic inv, input logic eret, input word_t pc);
        except_t x;
        x.inst_invalid = inv;
        x.is_eret      = eret;
        x.pc           = pc;
        return x;
    endfunction

    function automatic jump_t make_jump(input logic taken, input word_t target);
        jump_t j;
        j.taken  = taken;
        j.target = target;
        return j;
    endfunction

    // Fields without meaning are zeroed before comparing
    function automatic logic [95:0] req_view(input rd_req_t r);
        if (!r.reg1_read)
            r.reg1_addr = '0;
        if (!r.reg2_read)
            r.reg2_addr = '0;
        return {84'd0, r};
    endfunction

    function automatic logic [95:0] ex_view(input id_ex_t e);
        if (!e.w_reg)
            e.w_dest = '0;
        return {46'd0, e};
    endfunction

    function automatic logic [95:0] jump_view(input jump_t j);
        if (!j.taken)
            j.target = '0;
        return {63'd0, j};
    endfunction

    task automatic check(input logic [95:0] actual, input logic [95:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at time %0t: %s got %0h expected %0h",
                     $time, what, actual, expected);
        end else begin
            passes++;
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished, %0d failed checks so far", name, errors);
    endtask

    // One instruction through ID and its registered image in EX
    task automatic run_inst(input word_t word, input word_t pc, input rd_req_t exp_req,
                            input jump_t exp_jmp, input id_ex_t exp_ex,
                            input except_t exp_exc, input string name);
        @(negedge clk);
        inst_i = word;
        pc_i   = pc;
        #1;
        check(req_view(rd_req_o), req_view(exp_req), {name, " rd_req_o"});
        check(jump_view(jump_o), jump_view(exp_jmp), {name, " jump_o"});
        check({95'd0, stall_o}, '0, {name, " stall_o"});
        @(posedge clk);
        #1;
        check(ex_view(ex_o), ex_view(exp_ex), {name, " ex_o"});
        check({62'd0, exc_o}, {62'd0, exp_exc}, {name, " exc_o"});
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic reset_sequence();
        rst_i  = 1'b1;
        inst_i = i_inst(OP_ORI, 5'd1, 5'd2, 16'h1234);   // Must not reach EX
        pc_i   = 32'h0000_0100;
        repeat (8) begin
            @(posedge clk);
            #1;
            check({46'd0, ex_o}, '0, "reset ex_o");
            check({62'd0, exc_o}, '0, "reset exc_o");
            check({95'd0, stall_o}, '0, "reset stall_o");
        end
        @(negedge clk);
        rst_i = 1'b0;
        #1;
        check({46'd0, ex_o}, '0, "after reset ex_o");
        check({95'd0, stall_o}, '0, "after reset stall_o");
        report_test("reset");
    endtask

    task automatic rtype_ops();
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sh;
        word_t      pc;
        logic [5:0] fn;
        alu_op_e    op;
        alu_sel_e   sel;
        for (int i = 0; i < 12; i++) begin
            rs = rand_reg();
            rt = rand_reg();
            rd = rand_reg();
            sh = rand_reg();
            pc = rand32();
            case (i % 6)
                0: begin
                    fn  = FN_AND;
                    op  = AND_OP;
                    sel = SEL_LOGIC;
                end
                1: begin
                    fn  = FN_OR;
                    op  = OR_OP;
                    sel = SEL_LOGIC;
                end
                2: begin
                    fn  = FN_SUB;
                    op  = SUB_OP;
                    sel = SEL_ARITH;
                end
                3: begin
                    fn  = FN_SLTU;
                    op  = SLTU_OP;
                    sel = SEL_ARITH;
                end
                4: begin
                    fn  = FN_SLLV;
                    op  = SLL_OP;
                    sel = SEL_SHIFT;
                end
                default: begin
                    fn  = FN_SRA;
                    op  = SRA_OP;
                    sel = SEL_SHIFT;
                end
            endcase
            if (fn == FN_SRA)   // Constant shift needs a zero rs field
                run_inst(r_inst(5'd0, rt, rd, sh, fn), pc, make_req(1'b0, '0, 1'b1, rt),
                         make_jump(1'b0, '0), make_ex(sel, op, 1'b1, rd, {27'd0, sh}),
                         make_exc(1'b0, 1'b0, pc), "rtype");
            else
                run_inst(r_inst(rs, rt, rd, 5'd0, fn), pc, make_req(1'b1, rs, 1'b1, rt),
                         make_jump(1'b0, '0), make_ex(sel, op, 1'b1, rd, '0),
                         make_exc(1'b0, 1'b0, pc), "rtype");
        end
        report_test("rtype_and_shifts");
    endtask

    task automatic immediate_ops();
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
        word_t       pc;
        logic [5:0]  opc;
        alu_op_e     op;
        alu_sel_e    sel;
        word_t       exp_imm;
        for (int i = 0; i < 16; i++) begin
            rs  = rand_reg();
            rt  = rand_reg();
            imm = rand_imm();
            pc  = rand32();
            if (i < 8)
                imm[15] = 1'b1;   // First pass all negative
            sel     = SEL_ARITH;
            exp_imm = {{16{imm[15]}}, imm};
            case (i % 8)
                0: begin
                    opc = OP_ORI;
                    op  = OR_OP;
                end
                1: begin
                    opc = OP_ANDI;
                    op  = AND_OP;
                end
                2: begin
                    opc = OP_XORI;
                    op  = XOR_OP;
                end
                3: begin
                    opc = OP_ADDI;
                    op  = ADD_OP;
                end
                4: begin
                    opc = OP_ADDIU;
                    op  = ADDU_OP;
                end
                5: begin
                    opc = OP_SLTI;
                    op  = SLT_OP;
                end
                6: begin
                    opc = OP_SLTIU;
                    op  = SLTU_OP;
                end
                default: begin
                    opc = OP_LUI;
                    op  = OR_OP;
                    rs  = '0;
                end
            endcase
            if (i % 8 < 3) begin
                sel     = SEL_LOGIC;
                exp_imm = {16'h0000, imm};
            end else if (i % 8 == 7) begin
                sel     = SEL_LOGIC;
                exp_imm = {imm, 16'h0000};
            end
            run_inst(i_inst(opc, rs, rt, imm), pc, make_req(1'b1, rs, 1'b0, '0),
                     make_jump(1'b0, '0), make_ex(sel, op, 1'b1, rt, exp_imm),
                     make_exc(1'b0, 1'b0, pc), "immediate");
        end
        report_test("immediates");
    endtask

    task automatic jump_ops();
        logic [31:0] v;
        word_t       pc;
        word_t       target;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        for (int i = 0; i < 2; i++) begin
            v      = rand32();
            pc     = rand32();
            target = {pc[31:28] + {3'd0, &pc[27:2]}, v[25:0], 2'b00};   // Top of PC+4
            run_inst(j_inst(i == 0 ? OP_J : OP_JAL, v[25:0]), pc,
                     make_req(1'b0, '0, 1'b0, '0), make_jump(1'b1, target),
                     make_ex(SEL_JUMP_BRANCH, i == 0 ? J_OP : JAL_OP, i[0], REG_RA, '0),
                     make_exc(1'b0, 1'b0, pc), i == 0 ? "J" : "JAL");
        end
        for (int i = 0; i < 2; i++) begin
            rs  = rand_reg();
            rt  = rand_reg();
            imm = rand_imm();
            pc  = rand32();
            run_inst(i_inst(i == 0 ? OP_BEQ : OP_BNE, rs, rt, imm), pc,
                     make_req(1'b1, rs, 1'b1, rt), make_jump(1'b0, '0),
                     make_ex(SEL_JUMP_BRANCH, i == 0 ? BEQ_OP : BNE_OP, 1'b0, '0,
                             {{16{imm[15]}}, imm}),
                     make_exc(1'b0, 1'b0, pc), i == 0 ? "BEQ" : "BNE");
        end
        rs = rand_reg();
        rd = rand_reg();
        pc = rand32();
        run_inst(r_inst(rs, 5'd0, rd, 5'd0, FN_JR), pc, make_req(1'b1, rs, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_JUMP_BRANCH, JR_OP, 1'b0, '0, '0),
                 make_exc(1'b0, 1'b0, pc), "JR");
        run_inst(r_inst(rs, 5'd0, rd, 5'd0, FN_JALR), pc, make_req(1'b1, rs, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_JUMP_BRANCH, JALR_OP, 1'b1, rd, '0),
                 make_exc(1'b0, 1'b0, pc), "JALR");
        report_test("jumps_and_branches");
    endtask

    task automatic load_use_stall();
        reg_addr_t r;
        reg_addr_t base;
        reg_addr_t rd;
        word_t     pc;
        word_t     add_word;
        r    = (rand_reg() % 5'd31) + 5'd1;   // Never r0
        base = rand_reg();
        rd   = rand_reg();
        pc   = rand32();
        run_inst(i_inst(OP_LW, base, r, 16'hfff0), pc, make_req(1'b1, base, 1'b0, '0),
                 make_jump(1'b0, '0),
                 make_ex(SEL_LOAD_STORE, LW_OP, 1'b1, r, 32'hffff_fff0),
                 make_exc(1'b0, 1'b0, pc), "LW");
        add_word = r_inst(r, base, rd, 5'd0, FN_ADD);
        @(negedge clk);
        inst_i = add_word;
        pc_i   = pc + 32'd4;
        #1;
        check({95'd0, stall_o}, 96'd1, "load-use stall_o high");
        @(posedge clk);
        #1;
        check({46'd0, ex_o}, '0, "load-use bubble ex_o");
        check({62'd0, exc_o}, '0, "load-use bubble exc_o");
        check({95'd0, stall_o}, '0, "load-use stall_o low");
        @(posedge clk);
        #1;
        check(ex_view(ex_o), ex_view(make_ex(SEL_ARITH, ADD_OP, 1'b1, rd, '0)),
              "held ADD ex_o");
        check({62'd0, exc_o}, {62'd0, make_exc(1'b0, 1'b0, pc + 32'd4)}, "held ADD exc_o");

        // Load into r0 never stalls
        run_inst(i_inst(OP_LW, base, 5'd0, 16'h0004), pc, make_req(1'b1, base, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_LOAD_STORE, LW_OP, 1'b1, 5'd0, 32'd4),
                 make_exc(1'b0, 1'b0, pc), "LW r0");
        run_inst(r_inst(5'd0, 5'd0, rd, 5'd0, FN_ADD), pc, make_req(1'b1, '0, 1'b1, '0),
                 make_jump(1'b0, '0), make_ex(SEL_ARITH, ADD_OP, 1'b1, rd, '0),
                 make_exc(1'b0, 1'b0, pc), "ADD r0");

        // Matching fields but no reads enabled
        run_inst(i_inst(OP_LW, base, r, 16'h0008), pc, make_req(1'b1, base, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_LOAD_STORE, LW_OP, 1'b1, r, 32'd8),
                 make_exc(1'b0, 1'b0, pc), "LW again");
        run_inst(j_inst(OP_COP0, {RS_MFC0, r, r, 11'd0}), pc, make_req(1'b0, '0, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_MOVE, MFC0_OP, 1'b1, r, '0),
                 make_exc(1'b0, 1'b0, pc), "MFC0 after LW");
        report_test("load_use");
    endtask

    task automatic cop0_ops();
        reg_addr_t   rt;
        reg_addr_t   rd;
        word_t       pc;
        logic [31:0] v;
        rt = rand_reg();
        rd = rand_reg();
        pc = rand32();
        v  = rand32();
        run_inst(j_inst(OP_COP0, {RS_MFC0, rt, rd, 11'd0}), pc, make_req(1'b0, '0, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_MOVE, MFC0_OP, 1'b1, rt, '0),
                 make_exc(1'b0, 1'b0, pc), "MFC0");
        run_inst(j_inst(OP_COP0, {RS_MTC0, rt, rd, 11'd0}), pc, make_req(1'b1, rt, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_MOVE, MTC0_OP, 1'b0, '0, '0),
                 make_exc(1'b0, 1'b0, pc), "MTC0");
        run_inst(j_inst(OP_COP0, {RS_ERET, 15'd0, 6'b011000}), pc,
                 make_req(1'b0, '0, 1'b0, '0), make_jump(1'b0, '0),
                 make_ex(SEL_NOP, ERET_OP, 1'b0, '0, '0), make_exc(1'b0, 1'b1, pc), "ERET");
        run_inst(j_inst(6'b111111, v[25:0]), v, make_req(1'b0, '0, 1'b0, '0),
                 make_jump(1'b0, '0), make_ex(SEL_NOP, NOP_OP, 1'b0, '0, '0),
                 make_exc(1'b1, 1'b0, v), "undefined opcode");
        report_test("coprocessor_and_exceptions");
    endtask

    initial begin
        rst_i  = 1'b1;
        inst_i = '0;
        pc_i   = '0;
        reset_sequence();
        rtype_ops();
        immediate_ops();
        jump_ops();
        load_use_stall();
        cop0_ops();
        $display("Checks passed: %0d, failed: %0d", passes, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/load_use_hazard.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
bench/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
verilator --binary --timing --top-module tb_id_stage -f src.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    && grep -q "^STATUS: PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
